/* list.f */
+incdir+design
design/doe_defines_pkg.sv
design/doe_reg_pkg.sv
design/doe_regs.sv
design/doe_cipher_core.sv
design/doe_block_counter.sv
design/doe_fsm.sv
design/doe_cbc.sv
verif/tb_doe_cbc.sv

/* Makefile */
# Verilator build and run of the deobfuscation engine testbench

VERILATOR ?= verilator
TOP       ?= tb_doe_cbc
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/doe_patterns.hex */
// One 32-bit word per line, in this order:
// key[0:7] (word 0 on top), seed[0:11], entropy[0:7], iv[0:3],
// expected UDS kv dwords[0:11], second iv[0:3], expected FE kv dwords[0:7]
// Obfuscation key, one bit set in each half
00000000
00000000
00000000
00000001
00000000
00000000
00000000
00000001
// Obfuscated UDS seed
01020304
05060708
090A0B0C
0D0E0F10
11121314
15161718
191A1B1C
1D1E1F20
21222324
25262728
292A2B2C
2D2E2F30
// Obfuscated field entropy
40414243
44454647
48494A4B
4C4D4E4F
50515253
54555657
58595A5B
5C5D5E5F
// First IV
A0000000
0B000000
00C00000
000D0000
// Expected UDS kv dwords
A40D0687
0B098A03
0C4D060F
900C0203
151F1593
151F9D1B
15971D13
AD1F1D03
353F35B3
353FBD3B
35B73D33
AD3F3D03
// Second IV
12345678
9ABCDEF0
0F0F0F0F
F0F0F0F0
// Expected FE kv dwords
517813BE
D5F417B2
44C34A41
3FB0B1B2
131D1795
1B1D9F15
13951F15
931D1F1D

/* verif/tb_doe_cbc.sv */
`timescale 1ns/1ps
`include "doe_defines.svh"

module tb_doe_cbc;
  import doe_defines_pkg::*;

  localparam int TIMEOUT = 200;
  // Word positions in the pattern file
  localparam int P_KEY = 0;
  localparam int P_SEED = 8;
  localparam int P_ENT = 20;
  localparam int P_IV = 28;
  localparam int P_EXP_UDS = 32;
  localparam int P_IV2 = 44;
  localparam int P_EXP_FE = 48;
  // STATUS bits
  localparam logic [31:0] ST_READY = 32'h01;
  localparam logic [31:0] ST_VALID = 32'h02;
  localparam logic [31:0] ST_UDS = 32'h04;
  localparam logic [31:0] ST_FE = 32'h08;
  localparam logic [31:0] ST_CLR = 32'h10;

  logic                          clk;
  logic                          reset_n;
  logic                          cptra_pwrgood;
  logic                          cs;
  logic                          we;
  logic [7:0]                    address;
  logic [31:0]                   write_data;
  logic [`DOE_KEY_DWORDS*32-1:0] cptra_obf_key;
  logic [`DOE_UDS_DWORDS*32-1:0] obf_uds_seed;
  logic [`DOE_FE_DWORDS*32-1:0]  obf_field_entropy;
  logic [31:0]                   read_data;
  logic                          error_intr;
  logic                          notif_intr;
  logic                          clear_obf_secrets;
  kv_write_t                     kv_write;

  logic [31:0] pat [0:55];
  kv_write_t   kv_q[$];
  int          clear_count;
  logic [4:0]  dest;
  logic [31:0] rdata;

  doe_cbc dut0 (
    .clk               (clk),
    .reset_n           (reset_n),
    .cptra_pwrgood     (cptra_pwrgood),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .cptra_obf_key     (cptra_obf_key),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .read_data         (read_data),
    .error_intr        (error_intr),
    .notif_intr        (notif_intr),
    .clear_obf_secrets (clear_obf_secrets),
    .kv_write          (kv_write)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // Monitor of kv writes and clear pulses
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (kv_write.write_en) begin
      kv_q.push_back(kv_write);
    end
    if (clear_obf_secrets) begin
      clear_count++;
    end
  end

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    assert (actual === expected) else begin
      $display("Error: time %0d ns, %s: got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timed out waiting for %s", what);
    stop_run();
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(posedge clk);
    #2;
    cs = 1'b0;
    we = 1'b0;
  endtask

  // read_data is combinational, sampled mid-cycle
  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    #10;
    data = read_data;
    @(posedge clk);
    #2;
    cs = 1'b0;
  endtask

  task automatic wait_kv(input int count, input string what);
    int i;
    for (i = 0; i < TIMEOUT && kv_q.size() < count; i++) begin
      @(posedge clk);
    end
    if (kv_q.size() < count) timed_out(what);
  endtask

  task automatic wait_status(input logic [31:0] bits, input string what);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < TIMEOUT && (value & bits) != bits; i++) begin
      bus_read(8'h14, value);
    end
    if ((value & bits) != bits) timed_out(what);
  endtask

  // Pops and compares one flow's kv writes
  task automatic check_kv(input int base, input int count, input logic [4:0] entry);
    kv_write_t w;
    for (int i = 0; i < count; i++) begin
      w = kv_q.pop_front();
      check_value(w.write_entry, entry, $sformatf("kv entry of dword %0d", i));
      check_value(w.write_offset, i, $sformatf("kv offset of dword %0d", i));
      check_value(w.write_data, pat[base+i], $sformatf("kv data of dword %0d", i));
    end
  endtask

  task automatic write_iv(input int base);
    for (int i = 0; i < 4; i++) begin
      bus_write(8'(4 * i), pat[base+i]);
    end
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    cptra_pwrgood = 1'b0;
    cs = 1'b0;
    we = 1'b0;
    address = '0;
    write_data = '0;
    cptra_obf_key = '0;
    obf_uds_seed = '0;
    obf_field_entropy = '0;
    clear_count = 0;
    void'($urandom(32'ha5669841));
    $readmemh("verif/doe_patterns.hex", pat);
    if ($isunknown(pat[55])) begin
      $display("Pattern file verif/doe_patterns.hex is missing or too short");
      stop_run();
    end
    // Key word 0 on top, seed and entropy word 0 at the bottom
    for (int n = 0; n < 8; n++) begin
      cptra_obf_key[255-32*n -: 32] = pat[P_KEY+n];
    end
    for (int n = 0; n < 12; n++) begin
      obf_uds_seed[32*n +: 32] = pat[P_SEED+n];
    end
    for (int n = 0; n < 8; n++) begin
      obf_field_entropy[32*n +: 32] = pat[P_ENT+n];
    end

    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;
    cptra_pwrgood = 1'b1;

    // ----------------------------------------------------------
    // Reset state
    // ----------------------------------------------------------
    wait_status(ST_READY, "STATUS ready after reset");
    check_value(kv_write.write_en, 0, "kv write_en after reset");
    check_value(notif_intr, 0, "notif_intr after reset");
    check_value(error_intr, 0, "error_intr after reset");
    check_value(clear_obf_secrets, 0, "clear_obf_secrets after reset");

    // UDS flow with notification interrupt
    dest = 5'($urandom % 32);
    bus_write(8'h18, 32'h3);
    write_iv(P_IV);
    bus_write(8'h10, {25'b0, dest, 2'd1});
    wait_kv(12, "UDS kv writes");
    check_kv(P_EXP_UDS, 12, dest);
    wait_status(ST_VALID | ST_UDS, "STATUS valid and uds_done");
    bus_read(8'h10, rdata);
    check_value(rdata[1:0], 0, "CTRL cmd after UDS flow");
    check_value(notif_intr, 1, "notif_intr after UDS flow");
    bus_write(8'h1C, 32'h1);
    check_value(notif_intr, 0, "notif_intr after write one to clear");

    // FE flow, chain reloaded from the second IV
    dest = 5'($urandom % 32);
    write_iv(P_IV2);
    bus_write(8'h10, {25'b0, dest, 2'd2});
    wait_kv(8, "FE kv writes");
    check_kv(P_EXP_FE, 8, dest);
    wait_status(ST_VALID | ST_FE, "STATUS valid and fe_done");

    // ----------------------------------------------------------
    // Lock violation and lock reset
    // ----------------------------------------------------------
    bus_write(8'h1C, 32'h3);
    bus_write(8'h10, {25'b0, dest, 2'd1});
    for (int i = 0; i < TIMEOUT && !error_intr; i++) begin
      @(posedge clk);
    end
    if (!error_intr) timed_out("error_intr on locked UDS command");
    repeat (60) @(posedge clk);
    check_value(kv_q.size(), 0, "kv writes on locked command");
    bus_read(8'h14, rdata);
    check_value(rdata & ST_UDS, ST_UDS, "uds_done after lock violation");
    // Warm reset keeps both locks
    @(posedge clk);
    #2;
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;
    bus_read(8'h14, rdata);
    check_value(rdata & (ST_UDS | ST_FE), ST_UDS | ST_FE, "locks after reset_n pulse");
    @(posedge clk);
    #2;
    cptra_pwrgood = 1'b0;
    @(posedge clk);
    #2;
    cptra_pwrgood = 1'b1;
    bus_read(8'h14, rdata);
    check_value(rdata & (ST_UDS | ST_FE), 0, "locks after cptra_pwrgood low");

    // Clear command
    clear_count = 0;
    bus_write(8'h10, {30'b0, 2'd3});
    for (int i = 0; i < TIMEOUT && clear_count == 0; i++) begin
      @(posedge clk);
    end
    if (clear_count == 0) timed_out("clear_obf_secrets pulse");
    wait_status(ST_CLR | ST_VALID, "STATUS secrets_cleared and valid");
    check_value(clear_count, 1, "clear_obf_secrets pulse count");
    check_value(clear_obf_secrets, 0, "clear_obf_secrets after pulse");

    $display("TEST OK");
    $finish;
  end

endmodule

/* design/doe_cbc.sv */
`timescale 1ns/1ps
`include "doe_defines.svh"

module doe_cbc (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cptra_pwrgood,
  input  logic                           cs,
  input  logic                           we,
  input  logic [7:0]                     address,
  input  logic [31:0]                    write_data,
  input  logic [`DOE_KEY_DWORDS*32-1:0]  cptra_obf_key,
  input  logic [`DOE_UDS_DWORDS*32-1:0]  obf_uds_seed,
  input  logic [`DOE_FE_DWORDS*32-1:0]   obf_field_entropy,
  output logic [31:0]                    read_data,
  output logic                           error_intr,
  output logic                           notif_intr,
  output logic                           clear_obf_secrets,
  output doe_defines_pkg::kv_write_t     kv_write
);
  import doe_defines_pkg::*;
  import doe_reg_pkg::*;

  doe_reg_out_t reg_out;
  doe_reg_in_t  reg_in;
  doe_block_t   block_msg;
  doe_block_t   core_result;
  doe_idx_t     block_idx;
  doe_idx_t     dword_idx;
  logic         init_cmd;
  logic         next_cmd;
  logic         core_ready;
  logic         core_valid;
  logic         start;
  logic         block_step;
  logic         dword_step;
  logic         is_uds;
  logic         last_block;
  logic         last_dword;

  // ----------------------------------------------------------
  // Register file
  // ----------------------------------------------------------
  doe_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .reg_in     (reg_in),
    .read_data  (read_data),
    .reg_out    (reg_out),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  // Flow control
  doe_fsm u_fsm (
    .clk               (clk),
    .reset_n           (reset_n),
    .cptra_pwrgood     (cptra_pwrgood),
    .reg_out           (reg_out),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .core_ready        (core_ready),
    .core_result       (core_result),
    .core_valid        (core_valid),
    .block_idx         (block_idx),
    .dword_idx         (dword_idx),
    .last_block        (last_block),
    .last_dword        (last_dword),
    .init_cmd          (init_cmd),
    .next_cmd          (next_cmd),
    .block_msg         (block_msg),
    .start             (start),
    .block_step        (block_step),
    .dword_step        (dword_step),
    .is_uds            (is_uds),
    .kv_write          (kv_write),
    .reg_in            (reg_in),
    .clear_obf_secrets (clear_obf_secrets)
  );

  doe_block_counter u_counter (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .block_step (block_step),
    .dword_step (dword_step),
    .is_uds     (is_uds),
    .block_idx  (block_idx),
    .dword_idx  (dword_idx),
    .last_block (last_block),
    .last_dword (last_dword)
  );

  // Decryptor, key taken straight from the port
  doe_cipher_core u_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .key          (cptra_obf_key),
    .block_msg    (block_msg),
    .iv           (reg_out.iv),
    .iv_load      (reg_out.iv_written),
    .ready        (core_ready),
    .result       (core_result),
    .result_valid (core_valid)
  );

endmodule

/* design/doe_fsm.sv */
`timescale 1ns/1ps
`include "doe_defines.svh"

module doe_fsm (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             cptra_pwrgood,
  input  doe_reg_pkg::doe_reg_out_t        reg_out,
  input  logic [`DOE_UDS_DWORDS*32-1:0]    obf_uds_seed,
  input  logic [`DOE_FE_DWORDS*32-1:0]     obf_field_entropy,
  input  logic                             core_ready,
  input  doe_defines_pkg::doe_block_t      core_result,
  input  logic                             core_valid,
  input  doe_defines_pkg::doe_idx_t        block_idx,
  input  doe_defines_pkg::doe_idx_t        dword_idx,
  input  logic                             last_block,
  input  logic                             last_dword,
  output logic                             init_cmd,
  output logic                             next_cmd,
  output doe_defines_pkg::doe_block_t      block_msg,
  output logic                             start,
  output logic                             block_step,
  output logic                             dword_step,
  output logic                             is_uds,
  output doe_defines_pkg::kv_write_t       kv_write,
  output doe_reg_pkg::doe_reg_in_t         reg_in,
  output logic                             clear_obf_secrets
);
  import doe_defines_pkg::*;
  import doe_reg_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    WAIT_INIT,
    LOAD,
    WAIT_RESULT,
    WRITE,
    DONE
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  logic                       is_uds_q;
  logic [`DOE_KV_ENTRY_W-1:0] dest_q;
  logic                       uds_lock_q;
  logic                       fe_lock_q;
  logic                       lock_err_q;
  logic                       clear_q;
  logic                       flow_cmd;
  logic                       cmd_locked;
  doe_block_t                 result_q;

  assign flow_cmd   = reg_out.cmd_strobe && (reg_out.cmd.cmd inside {DOE_UDS, DOE_FE});
  assign cmd_locked = (reg_out.cmd.cmd == DOE_UDS) ? uds_lock_q : fe_lock_q;

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (flow_cmd && !cmd_locked) state_d = INIT;
      INIT:        state_d = WAIT_INIT;
      // Ready is back one cycle after it drops
      WAIT_INIT:   if (!core_ready) state_d = LOAD;
      LOAD:        state_d = WAIT_RESULT;
      WAIT_RESULT: if (core_valid) state_d = WRITE;
      WRITE:       if (last_dword) state_d = last_block ? DONE : LOAD;
      DONE:        state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q    <= IDLE;
      is_uds_q   <= 1'b0;
      dest_q     <= '0;
      lock_err_q <= 1'b0;
      clear_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Commands outside IDLE are dropped
      lock_err_q <= (state_q == IDLE) && flow_cmd && cmd_locked;
      clear_q    <= (state_q == IDLE) && reg_out.cmd_strobe && (reg_out.cmd.cmd == DOE_CLEAR);
      if (state_q == IDLE && state_d == INIT) begin
        is_uds_q <= (reg_out.cmd.cmd == DOE_UDS);
        dest_q   <= reg_out.cmd.dest_sel;
      end
    end
  end

  // Flow locks survive warm reset
  always_ff @(posedge clk or negedge cptra_pwrgood) begin
    if (!cptra_pwrgood) begin
      uds_lock_q <= 1'b0;
      fe_lock_q  <= 1'b0;
    end else if (state_q == DONE) begin
      uds_lock_q <= uds_lock_q | is_uds_q;
      fe_lock_q  <= fe_lock_q | ~is_uds_q;
    end
  end

  // Hold the block result for the kv writes
  always_ff @(posedge clk) begin
    if (core_valid) begin
      result_q <= core_result;
    end
  end

  // Source block, dword 0 on top
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (is_uds_q) begin
        block_msg[127-32*i -: 32] = obf_uds_seed[32*(4*block_idx+i) +: 32];
      end else begin
        block_msg[127-32*i -: 32] = obf_field_entropy[32*(4*block_idx+i) +: 32];
      end
    end
  end

  assign init_cmd   = (state_q == INIT);
  assign start      = (state_q == INIT);
  assign next_cmd   = (state_q == LOAD);
  assign dword_step = (state_q == WRITE);
  assign block_step = dword_step && last_dword && !last_block;
  assign is_uds     = is_uds_q;

  // ----------------------------------------------------------
  // Key-vault port, one dword per WRITE cycle
  // ----------------------------------------------------------
  assign kv_write.write_en     = (state_q == WRITE);
  assign kv_write.write_entry  = dest_q;
  assign kv_write.write_offset = {block_idx, dword_idx};
  assign kv_write.write_data   = result_q[127-32*dword_idx -: 32];

  assign reg_in.flow_done   = (state_q == DONE);
  assign reg_in.flow_busy   = (state_q != IDLE);
  assign reg_in.core_ready  = core_ready;
  assign reg_in.uds_lock    = uds_lock_q;
  assign reg_in.fe_lock     = fe_lock_q;
  assign reg_in.clear_pulse = clear_q;
  assign reg_in.lock_error  = lock_err_q;
  assign clear_obf_secrets  = clear_q;

  a_next_ready: assert property (@(posedge clk) disable iff (!reset_n)
    next_cmd |-> core_ready);

  // kv writes run only in WRITE and stay inside the running flow's secret
  a_kv_write: assert property (@(posedge clk) disable iff (!reset_n)
    kv_write.write_en |-> (state_q == WRITE) &&
      (kv_write.write_offset < (is_uds_q ? `DOE_UDS_DWORDS : `DOE_FE_DWORDS)));

endmodule

/* design/doe_block_counter.sv */
`timescale 1ns/1ps
`include "doe_defines.svh"

module doe_block_counter (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  logic                      block_step,
  input  logic                      dword_step,
  input  logic                      is_uds,
  output doe_defines_pkg::doe_idx_t block_idx,
  output doe_defines_pkg::doe_idx_t dword_idx,
  output logic                      last_block,
  output logic                      last_dword
);
  import doe_defines_pkg::*;

  doe_idx_t last_idx;

  // Last block index of the running flow
  assign last_idx = is_uds ? doe_idx_t'(`DOE_UDS_DWORDS / 4 - 1)
                           : doe_idx_t'(`DOE_FE_DWORDS / 4 - 1);

  assign last_block = (block_idx == last_idx);
  assign last_dword = (dword_idx == '1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block_idx <= '0;
      dword_idx <= '0;
    end else if (start || (dword_step && last_dword && last_block)) begin
      // Idle at zero between flows
      block_idx <= '0;
      dword_idx <= '0;
    end else begin
      if (dword_step) begin
        dword_idx <= dword_idx + 1'b1;
      end
      if (block_step) begin
        block_idx <= block_idx + 1'b1;
      end
    end
  end

  a_block_range: assert property (@(posedge clk) disable iff (!reset_n)
    block_idx <= last_idx);

endmodule

/* design/doe_cipher_core.sv */
`timescale 1ns/1ps
`include "doe_defines.svh"

module doe_cipher_core (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           init_cmd,
  input  logic                           next_cmd,
  input  logic [`DOE_KEY_DWORDS*32-1:0]  key,
  input  doe_defines_pkg::doe_block_t    block_msg,
  input  doe_defines_pkg::doe_block_t    iv,
  input  logic                           iv_load,
  output logic                           ready,
  output doe_defines_pkg::doe_block_t    result,
  output logic                           result_valid
);
  import doe_defines_pkg::*;

  localparam int HALF    = `DOE_KEY_DWORDS * 16;
  localparam int ROUND_W = $clog2(`DOE_ROUNDS);
  localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(`DOE_ROUNDS - 1);

  logic [`DOE_KEY_DWORDS*32-1:0] key_q;
  doe_block_t                    state_q;
  doe_block_t                    chain_q;
  doe_block_t                    round_key;
  doe_block_t                    mixed;
  doe_block_t                    round_out;
  logic [ROUND_W-1:0]            round_q;
  logic                          busy;
  logic                          init_busy;

  function automatic doe_block_t rotl(input doe_block_t x, input logic [ROUND_W-1:0] n);
    rotl = (x << n) | (x >> (128 - n));
  endfunction

  // ----------------------------------------------------------
  // One round, r counts down from the last round
  // ----------------------------------------------------------
  always_comb begin
    // Upper key half on even rounds
    round_key = round_q[0] ? key_q[HALF-1:0] : key_q[2*HALF-1:HALF];
    round_key = rotl(round_key, round_q);
    mixed     = state_q ^ round_key;
    // Rotate right by 13
    round_out = {mixed[12:0], mixed[127:13]};
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_busy    <= 1'b0;
      busy         <= 1'b0;
      round_q      <= '0;
      result_valid <= 1'b0;
    end else begin
      // Key setup takes a single cycle
      init_busy    <= init_cmd;
      result_valid <= 1'b0;
      if (next_cmd) begin
        busy    <= 1'b1;
        round_q <= LAST_ROUND;
      end else if (busy) begin
        round_q <= round_q - 1'b1;
        if (round_q == '0) begin
          busy         <= 1'b0;
          result_valid <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (init_cmd) begin
      key_q <= key;
    end
    if (next_cmd) begin
      state_q <= block_msg;
    end else if (busy) begin
      state_q <= round_out;
    end
    // Last round, unchain and keep ciphertext for the next block
    if (busy && round_q == '0) begin
      result  <= round_out ^ chain_q;
      chain_q <= block_msg;
    end
    if (iv_load) begin
      chain_q <= iv;
    end
  end

  assign ready = ~busy & ~init_busy;

  // Engine must wait for the previous block
  a_no_next_busy: assert property (@(posedge clk) disable iff (!reset_n)
    next_cmd |-> !busy);

endmodule

/* design/doe_regs.sv */
`timescale 1ns/1ps

module doe_regs (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      cs,
  input  logic                      we,
  input  logic [7:0]                address,
  input  logic [31:0]               write_data,
  input  doe_reg_pkg::doe_reg_in_t  reg_in,
  output logic [31:0]               read_data,
  output doe_reg_pkg::doe_reg_out_t reg_out,
  output logic                      error_intr,
  output logic                      notif_intr
);
  import doe_defines_pkg::*;
  import doe_reg_pkg::*;

  logic [3:0][31:0] iv_q;
  doe_ctrl_word_u   ctrl_q;
  doe_ctrl_word_u   wr_word;
  doe_status_t      status;
  doe_intr_t        intr_en_q;
  doe_intr_t        intr_sts_q;
  logic             ready_q;
  logic             valid_q;
  logic             cleared_q;
  logic             strobe_q;
  logic             iv_wr_q;
  logic             wr_en;

  assign wr_en       = cs & we;
  assign wr_word.raw = write_data;

  // ----------------------------------------------------------
  // Software registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iv_q      <= '0;
      ctrl_q    <= '0;
      intr_en_q <= '0;
      strobe_q  <= 1'b0;
      iv_wr_q   <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      iv_wr_q  <= 1'b0;
      if (wr_en) begin
        case (address)
          DOE_IV0, DOE_IV1, DOE_IV2, DOE_IV3: begin
            iv_q[address[3:2]] <= write_data;
            iv_wr_q            <= 1'b1;
          end
          DOE_CTRL: begin
            ctrl_q   <= wr_word;
            // Only a real command starts the engine
            strobe_q <= (wr_word.fields.cmd != DOE_IDLE);
          end
          DOE_INTR_EN: intr_en_q <= doe_intr_t'(write_data[1:0]);
          default: ;
        endcase
      end
      // Engine retires the command
      if (reg_in.flow_done || reg_in.clear_pulse) begin
        ctrl_q.fields.cmd <= DOE_IDLE;
      end
    end
  end

  // ----------------------------------------------------------
  // Status and interrupt bits
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ready_q    <= 1'b0;
      valid_q    <= 1'b0;
      cleared_q  <= 1'b0;
      intr_sts_q <= '0;
    end else begin
      ready_q <= reg_in.core_ready & ~reg_in.flow_busy;
      // Set wins over a same-cycle CTRL write
      if (reg_in.flow_done || reg_in.clear_pulse) begin
        valid_q <= 1'b1;
      end else if (wr_en && address == DOE_CTRL) begin
        valid_q <= 1'b0;
      end
      if (reg_in.clear_pulse) begin
        cleared_q <= 1'b1;
      end
      // Write one to clear
      if (wr_en && address == DOE_INTR_STS) begin
        intr_sts_q <= intr_sts_q & ~doe_intr_t'(write_data[1:0]);
      end
      if (reg_in.flow_done) begin
        intr_sts_q.notif <= 1'b1;
      end
      if (reg_in.lock_error) begin
        intr_sts_q.error <= 1'b1;
      end
    end
  end

  assign status.ready           = ready_q;
  assign status.valid           = valid_q;
  assign status.uds_done        = reg_in.uds_lock;
  assign status.fe_done         = reg_in.fe_lock;
  assign status.secrets_cleared = cleared_q;

  // Read mux, zero outside a read
  always_comb begin
    read_data = '0;
    if (cs && !we) begin
      case (address)
        DOE_IV0, DOE_IV1, DOE_IV2, DOE_IV3: read_data = iv_q[address[3:2]];
        DOE_CTRL:     read_data = ctrl_q.raw;
        DOE_STATUS:   read_data = {27'b0, status};
        DOE_INTR_EN:  read_data = {30'b0, intr_en_q};
        DOE_INTR_STS: read_data = {30'b0, intr_sts_q};
        default:      read_data = '0;
      endcase
    end
  end

  assign reg_out.cmd.cmd      = ctrl_q.fields.cmd;
  assign reg_out.cmd.dest_sel = ctrl_q.fields.dest;
  assign reg_out.cmd_strobe   = strobe_q;
  // IV word 0 is the most significant
  assign reg_out.iv           = {iv_q[0], iv_q[1], iv_q[2], iv_q[3]};
  assign reg_out.iv_written   = iv_wr_q;

  assign error_intr = intr_sts_q.error & intr_en_q.error;
  assign notif_intr = intr_sts_q.notif & intr_en_q.notif;

  // Each CTRL write gives a single engine strobe
  a_single_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    strobe_q |=> !strobe_q);

endmodule

/* design/doe_reg_pkg.sv */
`include "doe_defines.svh"

package doe_reg_pkg;

  // Word offsets of the register map
  typedef enum logic [7:0] {
    DOE_IV0      = 8'h00,
    DOE_IV1      = 8'h04,
    DOE_IV2      = 8'h08,
    DOE_IV3      = 8'h0C,
    DOE_CTRL     = 8'h10,
    DOE_STATUS   = 8'h14,
    DOE_INTR_EN  = 8'h18,
    DOE_INTR_STS = 8'h1C
  } doe_reg_addr_e;

  // CTRL word, seen raw by the bus and as fields by the engine
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-`DOE_KV_ENTRY_W-2:0] rsvd;
      logic [`DOE_KV_ENTRY_W-1:0]    dest;
      doe_defines_pkg::doe_cmd_e     cmd;
    } fields;
  } doe_ctrl_word_u;

  // STATUS bits, ready in bit 0
  typedef struct packed {
    logic secrets_cleared;
    logic fe_done;
    logic uds_done;
    logic valid;
    logic ready;
  } doe_status_t;

  // Interrupt enable and status bits
  typedef struct packed {
    logic error;
    logic notif;
  } doe_intr_t;

  // Registers to engine
  typedef struct packed {
    doe_defines_pkg::doe_cmd_t cmd;
    logic                      cmd_strobe;
    logic [127:0]              iv;
    logic                      iv_written;
  } doe_reg_out_t;

  // Engine to registers
  typedef struct packed {
    logic flow_done;
    logic flow_busy;
    logic core_ready;
    logic uds_lock;
    logic fe_lock;
    logic clear_pulse;
    logic lock_error;
  } doe_reg_in_t;

endpackage

/* design/doe_defines_pkg.sv */
`include "doe_defines.svh"

package doe_defines_pkg;

  // ----------------------------------------------------------
  // Engine commands
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    DOE_IDLE  = 2'd0,
    DOE_UDS   = 2'd1,
    DOE_FE    = 2'd2,
    DOE_CLEAR = 2'd3
  } doe_cmd_e;

  // Command plus the key-vault entry it targets
  typedef struct packed {
    doe_cmd_e                   cmd;
    logic [`DOE_KV_ENTRY_W-1:0] dest_sel;
  } doe_cmd_t;

  // ----------------------------------------------------------
  // Key-vault write port
  // ----------------------------------------------------------
  typedef struct packed {
    logic                        write_en;
    logic [`DOE_KV_ENTRY_W-1:0]  write_entry;
    logic [`DOE_KV_OFFSET_W-1:0] write_offset;
    logic [31:0]                 write_data;
  } kv_write_t;

  // One 128-bit cipher block, dword 0 in the top bits
  typedef logic [127:0] doe_block_t;

  // Block or dword index within a flow
  typedef logic [1:0] doe_idx_t;

endpackage

/* design/doe_defines.svh */
`ifndef DOE_DEFINES_SVH
`define DOE_DEFINES_SVH

// Obfuscated secret sizes in dwords
`define DOE_UDS_DWORDS  12
`define DOE_FE_DWORDS   8

// Obfuscation key size in dwords
`define DOE_KEY_DWORDS  8

// Iterations of the round function per block
`define DOE_ROUNDS      8

// Key-vault write port widths
`define DOE_KV_ENTRY_W  5
`define DOE_KV_OFFSET_W 4

`endif
